// File: verilog.f
logic/stbuf_pkg.sv
logic/stbuf_entries.sv
logic/stbuf_ptrs.sv
logic/stbuf_fwd.sv
logic/store_buffer.sv
verif/store_buffer_props.sv
verif/store_buffer_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= store_buffer_tb
RTL_TOP   ?= store_buffer
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Finished with no errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/store_buffer_tb.sv
`timescale 1ns/1ns
`default_nettype none

module store_buffer_tb;

   import stbuf_pkg::*;

   typedef enum logic [2:0] {OP_IDLE, OP_ST, OP_ACK, OP_STACK, OP_LD} op_e;

   typedef struct packed {
      op_e     op;
      st_req_t req;
      addr_t   ld;
      logic    exp_empty;
      logic    exp_full;
      logic    exp_dv;
      drain_t  exp_drain;
      fwd_t    exp_fwd;
   } step_t;

   logic    clk;
   logic    arst_n;
   logic    st_valid;
   st_req_t st_req;
   logic    drain_ack;
   addr_t   ld_addr;
   logic    drain_valid;
   drain_t  drain;
   logic    full;
   logic    empty;
   fwd_t    fwd;

   step_t steps[$];
   int    wait_cnt;

   store_buffer DUT (
      .clk         (clk),
      .arst_n      (arst_n),
      .st_valid    (st_valid),
      .st_req      (st_req),
      .drain_ack   (drain_ack),
      .ld_addr     (ld_addr),
      .drain_valid (drain_valid),
      .drain       (drain),
      .full        (full),
      .empty       (empty),
      .fwd         (fwd)
   );

   bind store_buffer store_buffer_props u_props (
      .clk         (clk),
      .arst_n      (arst_n),
      .st_valid    (st_valid),
      .full        (full),
      .empty       (empty),
      .drain_valid (drain_valid)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   task automatic add_step(input op_e op, input st_req_t req, input addr_t ld,
                           input logic [2:0] flags, input drain_t d, input fwd_t f);
      step_t s;
      s.op = op;
      s.req = req;
      s.ld = ld;
      {s.exp_empty, s.exp_full, s.exp_dv} = flags;  // empty, full, drain_valid
      s.exp_drain = d;
      s.exp_fwd = f;
      steps.push_back(s);
   endtask

   function automatic data_t lane_mask(input byteen_t be);
      data_t m;
      for (int j = 0; j < BYTE_W; j++) begin
         m[8*j +: 8] = {8{be[j]}};
      end
      return m;
   endfunction

   task automatic value_error(input int idx, input string name,
                              input logic [63:0] exp, input logic [63:0] got);
      $display("[FAIL] step %0d %s expected %h got %h", idx, name, exp, got);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic apply_step(input step_t s);
      st_valid  = (s.op == OP_ST) || (s.op == OP_STACK);
      drain_ack = (s.op == OP_ACK) || (s.op == OP_STACK);
      st_req    = st_valid ? s.req : '0;
      ld_addr   = s.ld;
   endtask

   task automatic check_outputs(input int idx, input step_t s);
      data_t m;
      assert (empty === s.exp_empty) else value_error(idx, "empty", 64'(s.exp_empty), 64'(empty));
      assert (full === s.exp_full) else value_error(idx, "full", 64'(s.exp_full), 64'(full));
      assert (drain_valid === s.exp_dv)
         else value_error(idx, "drain_valid", 64'(s.exp_dv), 64'(drain_valid));
      if (s.exp_dv) begin
         m = lane_mask(s.exp_drain.byteen);  // unwritten lanes hold no defined data
         assert (drain.waddr === s.exp_drain.waddr)
            else value_error(idx, "drain.waddr", 64'(s.exp_drain.waddr), 64'(drain.waddr));
         assert (drain.byteen === s.exp_drain.byteen)
            else value_error(idx, "drain.byteen", 64'(s.exp_drain.byteen), 64'(drain.byteen));
         assert ((drain.data & m) === (s.exp_drain.data & m))
            else value_error(idx, "drain.data", 64'(s.exp_drain.data), 64'(drain.data));
      end
      assert (fwd.byteen === s.exp_fwd.byteen)
         else value_error(idx, "fwd.byteen", 64'(s.exp_fwd.byteen), 64'(fwd.byteen));
      assert (fwd.data === s.exp_fwd.data)
         else value_error(idx, "fwd.data", 64'(s.exp_fwd.data), 64'(fwd.data));
   endtask

   // ----------------------------------------
   // stimulus table
   // ----------------------------------------
   task automatic build_table();
      // reset state, any load misses
      add_step(OP_LD, '0, 16'h0010, 3'b100, '0, '0);
      // word store then forward
      add_step(OP_ST, '{16'h0100, SIZE_WORD, 32'hdeadbeef}, 16'h0100, 3'b001,
               '{14'h040, 4'hf, 32'hdeadbeef}, '{4'hf, 32'hdeadbeef});
      add_step(OP_LD, '0, 16'h0104, 3'b001, '{14'h040, 4'hf, 32'hdeadbeef}, '0);
      add_step(OP_ACK, '0, 16'h0100, 3'b100, '0, '0);
      // byte then half into one word
      add_step(OP_ST, '{16'h0200, SIZE_BYTE, 32'h000000a5}, 16'h0200, 3'b001,
               '{14'h080, 4'h1, 32'h000000a5}, '{4'h1, 32'h000000a5});
      add_step(OP_ST, '{16'h0202, SIZE_HALF, 32'h12340000}, 16'h0200, 3'b001,
               '{14'h080, 4'hd, 32'h123400a5}, '{4'hd, 32'h123400a5});
      add_step(OP_ACK, '0, 16'h0200, 3'b100, '0, '0);
      // fill up with four words
      add_step(OP_ST, '{16'h0300, SIZE_WORD, 32'h11111111}, 16'h0300, 3'b001,
               '{14'h0c0, 4'hf, 32'h11111111}, '{4'hf, 32'h11111111});
      add_step(OP_ST, '{16'h0304, SIZE_WORD, 32'h22222222}, 16'h0304, 3'b001,
               '{14'h0c0, 4'hf, 32'h11111111}, '{4'hf, 32'h22222222});
      add_step(OP_ST, '{16'h0308, SIZE_WORD, 32'h33333333}, 16'h0308, 3'b001,
               '{14'h0c0, 4'hf, 32'h11111111}, '{4'hf, 32'h33333333});
      add_step(OP_ST, '{16'h030c, SIZE_WORD, 32'h44444444}, 16'h0300, 3'b011,
               '{14'h0c0, 4'hf, 32'h11111111}, '{4'hf, 32'h11111111});
      add_step(OP_ACK, '0, 16'h030c, 3'b001,
               '{14'h0c1, 4'hf, 32'h22222222}, '{4'hf, 32'h44444444});
      // store and ack together, count holds at three
      add_step(OP_STACK, '{16'h0310, SIZE_WORD, 32'h55555555}, 16'h0310, 3'b001,
               '{14'h0c2, 4'hf, 32'h33333333}, '{4'hf, 32'h55555555});
      add_step(OP_ACK, '0, 16'h0304, 3'b001, '{14'h0c3, 4'hf, 32'h44444444}, '0);
      add_step(OP_ACK, '0, 16'h0300, 3'b001, '{14'h0c4, 4'hf, 32'h55555555}, '0);
      add_step(OP_ACK, '0, 16'h0310, 3'b100, '0, '0);
      // byte at offset 2
      add_step(OP_ST, '{16'h0402, SIZE_BYTE, 32'h00ab0000}, 16'h0400, 3'b001,
               '{14'h100, 4'h4, 32'h00ab0000}, '{4'h4, 32'h00ab0000});
      add_step(OP_ACK, '0, 16'h0402, 3'b100, '0, '0);
   endtask

   initial begin
      arst_n    = 1'b0;
      st_valid  = 1'b0;
      st_req    = '0;
      drain_ack = 1'b0;
      ld_addr   = '0;
      build_table();

      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      wait_cnt = 0;
      while (empty !== 1'b1 && wait_cnt < 20) begin
         @(posedge clk);
         wait_cnt++;
      end
      if (empty !== 1'b1) begin
         $display("empty did not rise after reset within 20 cycles");
         $display("Finished with errors");
         $fatal(1);
      end

      foreach (steps[i]) begin
         @(negedge clk);
         apply_step(steps[i]);
         @(posedge clk);
         #2;                       // settle, before the next falling edge
         check_outputs(i, steps[i]);
      end

      @(negedge clk);
      st_valid  = 1'b0;
      drain_ack = 1'b0;
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/store_buffer_props.sv
`timescale 1ns/1ns
`default_nettype none

module store_buffer_props (
   input logic clk,
   input logic arst_n,
   input logic st_valid,
   input logic full,
   input logic empty,
   input logic drain_valid
);

   // ----------------------------------------
   // caller protocol
   // ----------------------------------------
   no_store_when_full: assert property (@(posedge clk) disable iff (!arst_n)
      !(st_valid && full))
      else $error("store presented while buffer is full");

   // ----------------------------------------
   // status consistency
   // ----------------------------------------
   never_full_and_empty: assert property (@(posedge clk) disable iff (!arst_n)
      !(full && empty))
      else $error("full and empty high together");

   valid_tracks_empty: assert property (@(posedge clk) disable iff (!arst_n)
      drain_valid == !empty)
      else $error("drain_valid disagrees with empty");

   // first edge out of reset
   idle_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !drain_valid)
      else $error("drain_valid high right after reset");

endmodule

`default_nettype wire

// File: logic/store_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module store_buffer (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                st_valid,
   input  stbuf_pkg::st_req_t  st_req,
   input  logic                drain_ack,
   input  stbuf_pkg::addr_t    ld_addr,
   output logic                drain_valid,
   output stbuf_pkg::drain_t   drain,
   output logic                full,
   output logic                empty,
   output stbuf_pkg::fwd_t     fwd
);

   import stbuf_pkg::*;

   logic                          alloc;
   logic                          pop;
   ptr_t                          wr_ptr;
   ptr_t                          rd_ptr;
   logic [STBUF_DEPTH-1:0]        ent_valid;
   waddr_t  [STBUF_DEPTH-1:0]     ent_waddr;
   byteen_t [STBUF_DEPTH-1:0]     ent_byteen;
   data_t   [STBUF_DEPTH-1:0]     ent_data;

   stbuf_entries u_entries (
      .clk         (clk),
      .arst_n      (arst_n),
      .st_valid    (st_valid),
      .st_req      (st_req),
      .drain_ack   (drain_ack),
      .wr_ptr      (wr_ptr),
      .rd_ptr      (rd_ptr),
      .alloc       (alloc),
      .pop         (pop),
      .ent_valid   (ent_valid),
      .ent_waddr   (ent_waddr),
      .ent_byteen  (ent_byteen),
      .ent_data    (ent_data),
      .drain_valid (drain_valid),
      .drain       (drain)
   );

   stbuf_ptrs u_ptrs (
      .clk    (clk),
      .arst_n (arst_n),
      .alloc  (alloc),
      .pop    (pop),
      .wr_ptr (wr_ptr),
      .rd_ptr (rd_ptr),
      .full   (full),
      .empty  (empty)
   );

   // load side, same cycle
   stbuf_fwd u_fwd (
      .ld_addr    (ld_addr),
      .ent_valid  (ent_valid),
      .ent_waddr  (ent_waddr),
      .ent_byteen (ent_byteen),
      .ent_data   (ent_data),
      .fwd        (fwd)
   );

endmodule

`default_nettype wire

// File: logic/stbuf_fwd.sv
`timescale 1ns/1ns
`default_nettype none

module stbuf_fwd (
   input  stbuf_pkg::addr_t                                ld_addr,
   input  logic [stbuf_pkg::STBUF_DEPTH-1:0]               ent_valid,
   input  stbuf_pkg::waddr_t  [stbuf_pkg::STBUF_DEPTH-1:0] ent_waddr,
   input  stbuf_pkg::byteen_t [stbuf_pkg::STBUF_DEPTH-1:0] ent_byteen,
   input  stbuf_pkg::data_t   [stbuf_pkg::STBUF_DEPTH-1:0] ent_data,
   output stbuf_pkg::fwd_t                                 fwd
);

   import stbuf_pkg::*;

   waddr_t                 ld_waddr;
   logic [STBUF_DEPTH-1:0] hit;

   assign ld_waddr = ld_addr[ADDR_W-1:2];

   always_comb begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         hit[i] = ent_valid[i] & (ent_waddr[i] == ld_waddr);
      end
   end

   // ----------------------------------------
   // byte select
   // ----------------------------------------
   // coalescing leaves at most one hit, so an OR over entries is enough
   always_comb begin
      fwd = '0;
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         for (int j = 0; j < BYTE_W; j++) begin
            fwd.byteen[j]       = fwd.byteen[j] | (hit[i] & ent_byteen[i][j]);
            fwd.data[8*j +: 8]  = fwd.data[8*j +: 8] |
                                  ({8{hit[i] & ent_byteen[i][j]}} & ent_data[i][8*j +: 8]);
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/stbuf_ptrs.sv
`timescale 1ns/1ns
`default_nettype none

module stbuf_ptrs (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            alloc,
   input  logic            pop,
   output stbuf_pkg::ptr_t wr_ptr,
   output stbuf_pkg::ptr_t rd_ptr,
   output logic            full,
   output logic            empty
);

   import stbuf_pkg::*;

   cnt_t cnt;
   cnt_t cnt_nxt;

   // ----------------------------------------
   // occupancy
   // ----------------------------------------
   always_comb begin
      case ({alloc, pop})
         2'b10:   cnt_nxt = cnt + cnt_t'(1);
         2'b01:   cnt_nxt = cnt - cnt_t'(1);
         default: cnt_nxt = cnt;              // idle, or store and pop together
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
         full   <= 1'b0;
         empty  <= 1'b1;
      end else begin
         if (alloc) begin
            wr_ptr <= wr_ptr + ptr_t'(1);     // wraps at depth
         end
         if (pop) begin
            rd_ptr <= rd_ptr + ptr_t'(1);
         end
         cnt   <= cnt_nxt;
         full  <= (cnt_nxt == cnt_t'(STBUF_DEPTH));
         empty <= (cnt_nxt == '0);
      end
   end

endmodule

`default_nettype wire

// File: logic/stbuf_entries.sv
`timescale 1ns/1ns
`default_nettype none

module stbuf_entries (
   input  logic                                          clk,
   input  logic                                          arst_n,
   input  logic                                          st_valid,
   input  stbuf_pkg::st_req_t                            st_req,
   input  logic                                          drain_ack,
   input  stbuf_pkg::ptr_t                               wr_ptr,
   input  stbuf_pkg::ptr_t                               rd_ptr,
   output logic                                          alloc,
   output logic                                          pop,
   output logic [stbuf_pkg::STBUF_DEPTH-1:0]             ent_valid,
   output stbuf_pkg::waddr_t  [stbuf_pkg::STBUF_DEPTH-1:0] ent_waddr,
   output stbuf_pkg::byteen_t [stbuf_pkg::STBUF_DEPTH-1:0] ent_byteen,
   output stbuf_pkg::data_t   [stbuf_pkg::STBUF_DEPTH-1:0] ent_data,
   output logic                                          drain_valid,
   output stbuf_pkg::drain_t                             drain
);

   import stbuf_pkg::*;

   byteen_t                size_mask;
   byteen_t                st_byteen;
   waddr_t                 st_waddr;
   logic [STBUF_DEPTH-1:0] match;      // coalesce candidates
   logic [STBUF_DEPTH-1:0] rel;        // entry released this cycle
   logic [STBUF_DEPTH-1:0] wr_en;

   // ----------------------------------------
   // store decode
   // ----------------------------------------
   always_comb begin
      case (st_req.size)
         SIZE_BYTE: size_mask = 4'b0001;
         SIZE_HALF: size_mask = 4'b0011;
         SIZE_WORD: size_mask = 4'b1111;
         default:   size_mask = 4'b0000;
      endcase
   end

   assign st_byteen = size_mask << st_req.addr[1:0];  // aligned, never crosses the word
   assign st_waddr  = st_req.addr[ADDR_W-1:2];

   // top entry leaves when acked
   assign drain_valid = ent_valid[rd_ptr];
   assign pop         = drain_ack & drain_valid;

   // ----------------------------------------
   // match and write select
   // ----------------------------------------
   always_comb begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         rel[i]   = pop & (rd_ptr == ptr_t'(i));
         // an entry on its way out cannot take new bytes
         match[i] = ent_valid[i] & ~rel[i] & (ent_waddr[i] == st_waddr);
      end
   end

   assign alloc = st_valid & ~(|match);

   always_comb begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         wr_en[i] = st_valid & (match[i] | (alloc & (wr_ptr == ptr_t'(i))));
      end
   end

   // valid and byte enables
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ent_valid  <= '0;
         ent_byteen <= '0;
      end else begin
         for (int i = 0; i < STBUF_DEPTH; i++) begin
            if (wr_en[i]) begin
               ent_valid[i]  <= 1'b1;
               ent_byteen[i] <= (rel[i] ? '0 : ent_byteen[i]) | st_byteen;  // merge
            end else if (rel[i]) begin
               ent_valid[i]  <= 1'b0;
               ent_byteen[i] <= '0;
            end
         end
      end
   end

   // address and data, only the enabled lanes are overwritten
   always_ff @(posedge clk) begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         if (wr_en[i]) begin
            ent_waddr[i] <= st_waddr;
            for (int j = 0; j < BYTE_W; j++) begin
               if (st_byteen[j]) begin
                  ent_data[i][8*j +: 8] <= st_req.data[8*j +: 8];
               end
            end
         end
      end
   end

   // drain mux
   always_comb begin
      drain.waddr  = ent_waddr[rd_ptr];
      drain.byteen = ent_byteen[rd_ptr];
      drain.data   = ent_data[rd_ptr];
   end

endmodule

`default_nettype wire

// File: logic/stbuf_pkg.sv
`default_nettype none

package stbuf_pkg;

   // ----------------------------------------
   // sizes
   // ----------------------------------------
   localparam int STBUF_DEPTH = 4;
   localparam int ADDR_W      = 16;                   // byte address
   localparam int DATA_W      = 32;
   localparam int BYTE_W      = 4;                    // bytes per word
   localparam int PTR_W       = $clog2(STBUF_DEPTH);
   localparam int CNT_W       = PTR_W + 1;            // must hold the depth itself

   // ----------------------------------------
   // types
   // ----------------------------------------
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [ADDR_W-3:0] waddr_t;                // word address, offset bits stripped
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [BYTE_W-1:0] byteen_t;
   typedef logic [PTR_W-1:0]  ptr_t;
   typedef logic [CNT_W-1:0]  cnt_t;

   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } st_size_e;

   // store as presented by the lsu, data already lane aligned
   typedef struct packed {
      addr_t    addr;
      st_size_e size;
      data_t    data;
   } st_req_t;

   typedef struct packed {
      waddr_t  waddr;
      byteen_t byteen;
      data_t   data;
   } drain_t;

   typedef struct packed {
      byteen_t byteen;
      data_t   data;
   } fwd_t;

endpackage

`default_nettype wire
